/* verilog/audio_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Sample and buffer size defaults for the voice effect datapath.
// Modules take these as parameter defaults; the top level may override.
////////////////////////////////////////////////////////////////////////////

package audio_pkg;

    // Width of one audio sample on the shared bus
    localparam int SAMPLE_WIDTH = 8;

    // Ping-pong bank depth is 2**BUF_ADDR_WIDTH samples
    localparam int BUF_ADDR_WIDTH = 8;

endpackage

/* verilog/fx_mode_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Effect mode opcode and the read-rate dividers of the pitch shift modes.
// The mode is a level and only changes while reset is held.
////////////////////////////////////////////////////////////////////////////

package fx_mode_pkg;

    typedef enum logic [1:0]
    {
        fx_normal      = 2'd0,  // Straight pass-through
        fx_shift_light = 2'd1,  // Mild pitch drop
        fx_shift_deep  = 2'd2   // Strong pitch drop
    } fx_mode_e;

    // Clocks between read ticks
    localparam logic [6:0] SHIFT_LIGHT_DIV = 7'd16;
    localparam logic [6:0] SHIFT_DEEP_DIV  = 7'd64;

    // Rate counter covers 0 .. SHIFT_DEEP_DIV-1
    localparam int DIV_CNT_WIDTH = 6;

endpackage

/* verilog/read_scheduler.sv */
////////////////////////////////////////////////////////////////////////////
// Read side timing for the ping-pong buffers. Divides sck down to the
// read tick, walks the shared read pointer and swaps banks at the end of
// each bank period. Both channel buffers follow its outputs.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module read_scheduler
#(
    parameter int ADDR_WIDTH = audio_pkg::BUF_ADDR_WIDTH
)
(
    input  logic                   sck,
    input  logic                   rst_n,
    input  fx_mode_pkg::fx_mode_e  mode,
    output logic                   rd_tick,
    output logic                   swap,
    output logic                   bank_sel,
    output logic [ADDR_WIDTH-1:0]  rd_addr
);
    import fx_mode_pkg::*;

    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = '1;

    logic [6:0]               div;
    logic [6:0]               div_m1;
    logic [DIV_CNT_WIDTH-1:0] rate_cnt;

    // Normal mode keeps the light rate, nothing reads the buffers then
    always_comb
    begin
        case (mode)
            fx_shift_deep: div = SHIFT_DEEP_DIV;
            default:       div = SHIFT_LIGHT_DIV;
        endcase
    end

    assign div_m1  = div - 7'd1;
    assign rd_tick = (rate_cnt == '0);
    assign swap    = rd_tick && (rd_addr == LAST_ADDR);  // Last tick of the period

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rate_cnt <= '0;
            rd_addr  <= '0;
            bank_sel <= 1'b0;
        end
        else
        begin
            if (rate_cnt == div_m1[DIV_CNT_WIDTH-1:0])
                rate_cnt <= '0;
            else
                rate_cnt <= rate_cnt + 1'b1;

            if (rd_tick)
                rd_addr <= rd_addr + 1'b1;  // Wraps after LAST_ADDR
            if (swap)
                bank_sel <= ~bank_sel;
        end
    end

endmodule

/* verilog/pingpong_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// Two sample banks for one channel. The bank named by bank_sel fills at
// the input strobe rate until full; the other bank is read out at rd_addr
// without a clock. The full flag is released on each bank swap.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pingpong_buffer
#(
    parameter int DATA_WIDTH = audio_pkg::SAMPLE_WIDTH,
    parameter int ADDR_WIDTH = audio_pkg::BUF_ADDR_WIDTH
)
(
    input  logic                   sck,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic                   swap,
    input  logic                   bank_sel,
    input  logic [DATA_WIDTH-1:0]  wr_data,
    input  logic [ADDR_WIDTH-1:0]  rd_addr,
    output logic [DATA_WIDTH-1:0]  rd_data
);

    localparam int                    DEPTH     = 1 << ADDR_WIDTH;
    localparam logic [ADDR_WIDTH-1:0] LAST_ADDR = '1;

    logic [DATA_WIDTH-1:0] mem [0:1][0:DEPTH-1];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic                  full;
    logic                  wr_go;

    assign wr_go = wr_en && !full;  // Late samples are dropped

    ////////////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sck)
    begin
        if (wr_go)
            mem[bank_sel][wr_ptr] <= wr_data;
    end

    // Replay side sees the bank not being written
    assign rd_data = mem[~bank_sel][rd_addr];

    ////////////////////////////////////////////////////////////////////////////
    // Write pointer and full flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            full   <= 1'b0;
        end
        else
        begin
            if (wr_go)
            begin
                wr_ptr <= wr_ptr + 1'b1;
                if (wr_ptr == LAST_ADDR)
                    full <= 1'b1;
            end
            if (swap)
                full <= 1'b0;  // Fresh bank to fill
        end
    end

endmodule

/* verilog/stereo_out_reg.sv */
////////////////////////////////////////////////////////////////////////////
// Registered left and right outputs. Pass-through mode captures the bus
// on each channel strobe; the shift modes load buffer data on read ticks.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module stereo_out_reg
#(
    parameter int DATA_WIDTH = audio_pkg::SAMPLE_WIDTH
)
(
    input  logic                   sck,
    input  logic                   rst_n,
    input  logic                   l_vld,
    input  logic                   r_vld,
    input  logic                   rd_tick,
    input  fx_mode_pkg::fx_mode_e  mode,
    input  logic [DATA_WIDTH-1:0]  data,
    input  logic [DATA_WIDTH-1:0]  l_rd_data,
    input  logic [DATA_WIDTH-1:0]  r_rd_data,
    output logic [DATA_WIDTH-1:0]  ldata,
    output logic [DATA_WIDTH-1:0]  rdata
);
    import fx_mode_pkg::*;

    logic                  pass;
    logic                  l_load;
    logic                  r_load;

    assign pass   = (mode == fx_normal);
    assign l_load = pass ? l_vld : rd_tick;
    assign r_load = pass ? r_vld : rd_tick;

    always_ff @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ldata <= '0;
            rdata <= '0;
        end
        else
        begin
            if (l_load)
                ldata <= pass ? data : l_rd_data;
            if (r_load)
                rdata <= pass ? data : r_rd_data;
        end
    end

endmodule

/* verilog/voice_fx_top.sv */
////////////////////////////////////////////////////////////////////////////
// Stereo voice effect top level. Shared sample bus in, one strobe per
// channel, registered left and right out. Mode selects pass-through or
// pitch shift through ping-pong buffers; change it only under reset.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module voice_fx_top
#(
    parameter int DATA_WIDTH = audio_pkg::SAMPLE_WIDTH,
    parameter int ADDR_WIDTH = audio_pkg::BUF_ADDR_WIDTH
)
(
    input  logic                   sck,
    input  logic                   rst_n,
    input  logic                   l_vld,
    input  logic                   r_vld,
    input  fx_mode_pkg::fx_mode_e  mode,
    input  logic [DATA_WIDTH-1:0]  data,
    output logic [DATA_WIDTH-1:0]  ldata,
    output logic [DATA_WIDTH-1:0]  rdata
);

    logic                  rd_tick;
    logic                  swap;
    logic                  bank_sel;
    logic [ADDR_WIDTH-1:0] rd_addr;
    logic [DATA_WIDTH-1:0] l_rd_data;
    logic [DATA_WIDTH-1:0] r_rd_data;

    // Shared read timing for both channels
    read_scheduler #(.ADDR_WIDTH(ADDR_WIDTH)) i_read_scheduler
    (
        .sck      (sck),
        .rst_n    (rst_n),
        .mode     (mode),
        .rd_tick  (rd_tick),
        .swap     (swap),
        .bank_sel (bank_sel),
        .rd_addr  (rd_addr)
    );

    pingpong_buffer #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) i_buf_l
    (
        .sck      (sck),
        .rst_n    (rst_n),
        .wr_en    (l_vld),
        .swap     (swap),
        .bank_sel (bank_sel),
        .wr_data  (data),
        .rd_addr  (rd_addr),
        .rd_data  (l_rd_data)
    );

    pingpong_buffer #(.DATA_WIDTH(DATA_WIDTH), .ADDR_WIDTH(ADDR_WIDTH)) i_buf_r
    (
        .sck      (sck),
        .rst_n    (rst_n),
        .wr_en    (r_vld),
        .swap     (swap),
        .bank_sel (bank_sel),
        .wr_data  (data),
        .rd_addr  (rd_addr),
        .rd_data  (r_rd_data)
    );

    stereo_out_reg #(.DATA_WIDTH(DATA_WIDTH)) i_stereo_out_reg
    (
        .sck       (sck),
        .rst_n     (rst_n),
        .l_vld     (l_vld),
        .r_vld     (r_vld),
        .rd_tick   (rd_tick),
        .mode      (mode),
        .data      (data),
        .l_rd_data (l_rd_data),
        .r_rd_data (r_rd_data),
        .ldata     (ldata),
        .rdata     (rdata)
    );

endmodule

/* verif/tb_voice_fx.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the stereo voice effect top level. Runs the tests of the
// vector file with pass-through checks after every strobe and idle cycle
// and pitch shift checks on the replay ticks of the second bank period.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_voice_fx;
    import audio_pkg::*;
    import fx_mode_pkg::*;

    localparam int ADDR_W      = 2;
    localparam int DEPTH       = 1 << ADDR_W;
    localparam int LIGHT_DIV   = 16;
    localparam int DEEP_DIV    = 64;
    localparam int TEST_CYCLES = 10 + 2 * DEPTH * DEEP_DIV + 50;
    localparam     VEC_FILE    = "verif/voice_fx_vectors.txt";

    logic                    sck = 1'b0;
    logic                    rst_n;
    logic                    l_vld;
    logic                    r_vld;
    fx_mode_e                mode;
    logic [SAMPLE_WIDTH-1:0] data;
    logic [SAMPLE_WIDTH-1:0] ldata;
    logic [SAMPLE_WIDTH-1:0] rdata;

    integer                  fd;
    integer                  seed;
    int                      errors;
    int                      checks;
    int                      limit;
    int                      run_cyc;
    int                      cyc;        // Rising edges since reset release
    logic [8*16-1:0]         kind;
    logic [8*24-1:0]         tname;
    logic [8*128-1:0]        line;
    logic                    shifting;
    int                      exp_idx;
    int                      acc_l;
    int                      acc_r;
    logic [SAMPLE_WIDTH-1:0] hold_l;
    logic [SAMPLE_WIDTH-1:0] hold_r;
    logic [SAMPLE_WIDTH-1:0] drop_l[$];
    logic [SAMPLE_WIDTH-1:0] drop_r[$];

    voice_fx_top #(.DATA_WIDTH(SAMPLE_WIDTH), .ADDR_WIDTH(ADDR_W)) i_voice_fx_top
    (
        .sck   (sck),
        .rst_n (rst_n),
        .l_vld (l_vld),
        .r_vld (r_vld),
        .mode  (mode),
        .data  (data),
        .ldata (ldata),
        .rdata (rdata)
    );

    always #5 sck = ~sck;

    always @(posedge sck)
        run_cyc <= run_cyc + 1;

    always @(posedge sck or negedge rst_n)
    begin
        if (!rst_n)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_out(input logic [SAMPLE_WIDTH-1:0] exp_l,
                             input logic [SAMPLE_WIDTH-1:0] exp_r);
        checks += 2;
        assert (ldata === exp_l)
        else
        begin
            $display("ERR %0s ldata expected %h actual %h", tname, exp_l, ldata);
            errors++;
        end
        assert (rdata === exp_r)
        else
        begin
            $display("ERR %0s rdata expected %h actual %h", tname, exp_r, rdata);
            errors++;
        end
    endtask

    // Samples refused by a full bank must never be replayed
    task automatic check_drops;
        for (int i = 0; i < drop_l.size(); i++)
        begin
            assert (ldata !== drop_l[i])
            else
            begin
                $display("Test %0s: dropped left sample %h came out on ldata", tname, drop_l[i]);
                errors++;
            end
        end
        for (int i = 0; i < drop_r.size(); i++)
        begin
            assert (rdata !== drop_r[i])
            else
            begin
                $display("Test %0s: dropped right sample %h came out on rdata", tname, drop_r[i]);
                errors++;
            end
        end
    endtask

    function automatic int tick_period(input fx_mode_e m);
        return (m == fx_shift_deep) ? DEEP_DIV : LIGHT_DIV;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus driven on falling edges
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_test;
        logic [8*16-1:0] mode_word;
        int              code;
        tname     = '0;
        mode_word = '0;
        code      = $fscanf(fd, "%s %s", tname, mode_word);
        rst_n     = 1'b0;
        l_vld     = 1'b0;
        r_vld     = 1'b0;
        data      = '0;
        if (mode_word == "light")
            mode = fx_shift_light;
        else if (mode_word == "deep")
            mode = fx_shift_deep;
        else
            mode = fx_normal;
        if (mode == fx_normal && mode_word != "normal")
        begin
            $display("Test %0s names an unknown mode, running it as pass-through", tname);
            errors++;
        end
        shifting = (mode != fx_normal);
        hold_l   = '0;
        hold_r   = '0;
        acc_l    = 0;
        acc_r    = 0;
        exp_idx  = 0;
        drop_l.delete();
        drop_r.delete();
        limit += TEST_CYCLES;
        repeat (10) @(negedge sck);
        check_out(hold_l, hold_r);
        rst_n = 1'b1;
        @(negedge sck);
        if (!shifting)
            check_out(hold_l, hold_r);  // Shift modes replay an unwritten bank first
    endtask

    task automatic strobe_cycle(input logic left, input logic [SAMPLE_WIDTH-1:0] value);
        data  = value;
        l_vld = left;
        r_vld = !left;
        @(negedge sck);
        l_vld = 1'b0;
        r_vld = 1'b0;
    endtask

    task automatic take_sample(input logic left, input logic [SAMPLE_WIDTH-1:0] value);
        if (left && acc_l < DEPTH)
            acc_l++;
        else if (left)
            drop_l.push_back(value);
        else if (acc_r < DEPTH)
            acc_r++;
        else
            drop_r.push_back(value);  // Bank already full
    endtask

    task automatic apply_stim;
        logic [SAMPLE_WIDTH-1:0] sl;
        logic [SAMPLE_WIDTH-1:0] sr;
        int                      lv;
        int                      rv;
        int                      gap;
        int                      code;
        code = $fscanf(fd, "%h %h %d %d", sl, sr, lv, rv);
        if (lv != 0)
        begin
            strobe_cycle(1'b1, sl);
            if (shifting)
                take_sample(1'b1, sl);
            else
            begin
                hold_l = sl;
                check_out(hold_l, hold_r);
            end
        end
        if (rv != 0)
        begin
            strobe_cycle(1'b0, sr);
            if (shifting)
                take_sample(1'b0, sr);
            else
            begin
                hold_r = sr;
                check_out(hold_l, hold_r);
            end
        end
        if (!shifting)
        begin
            gap = $random(seed) & 3;
            repeat (gap)
            begin
                @(negedge sck);
                check_out(hold_l, hold_r);  // Outputs hold while idle
            end
        end
        else if (lv == 0 && rv == 0)
            @(negedge sck);
    endtask

    task automatic check_expect;
        logic [SAMPLE_WIDTH-1:0] el;
        logic [SAMPLE_WIDTH-1:0] er;
        int                      target;
        int                      code;
        code = $fscanf(fd, "%h %h", el, er);
        if (!shifting)
            check_out(el, er);
        else
        begin
            // Tick DEPTH+k replays address k of the first bank
            target = (DEPTH + exp_idx) * tick_period(mode) + 1;
            exp_idx++;
            while (cyc < target)
            begin
                @(negedge sck);
                check_drops;
            end
            if (cyc != target)
            begin
                $display("Test %0s: stimulus ran past replay tick %0d", tname,
                         DEPTH + exp_idx - 1);
                errors++;
            end
            else
            begin
                check_out(el, er);
                check_drops;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Vector file reader
    ////////////////////////////////////////////////////////////////////////////

    task automatic next_token(output int code);
        kind = '0;
        code = $fscanf(fd, "%s", kind);
        while (code == 1 && kind == "#")
        begin
            code = $fgets(line, fd);
            kind = '0;
            code = $fscanf(fd, "%s", kind);
        end
    endtask

    task automatic run_vectors;
        int code;
        next_token(code);
        while (code == 1)
        begin
            if (kind == "test")
                start_test;
            else if (kind == "stim")
                apply_stim;
            else if (kind == "expect")
                check_expect;
            else
            begin
                $display("Unknown record %0s in the vector file", kind);
                errors++;
                code = $fgets(line, fd);
            end
            next_token(code);
        end
    endtask

    initial
    begin : watchdog
        while (limit == 0 || run_cyc < limit)
            @(posedge sck);
        $display("Timeout after %0d clock cycles, the run did not finish", limit);
        $display("sim failed");
        $finish;
    end

    initial
    begin : main
        rst_n  = 1'b0;
        l_vld  = 1'b0;
        r_vld  = 1'b0;
        data   = '0;
        mode   = fx_normal;
        seed   = 32'h98c11a4e;
        errors = 0;
        checks = 0;
        limit  = 0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open the vector file %0s", VEC_FILE);
            errors++;
        end
        else
        begin
            run_vectors;
            $fclose(fd);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* filelist.f */
verilog/audio_pkg.sv
verilog/fx_mode_pkg.sv
verilog/read_scheduler.sv
verilog/pingpong_buffer.sv
verilog/stereo_out_reg.sv
verilog/voice_fx_top.sv
verif/tb_voice_fx.sv

/* Bender.yml */
package:
  name: voice_fx

sources:
  - verilog/audio_pkg.sv
  - verilog/fx_mode_pkg.sv
  - verilog/read_scheduler.sv
  - verilog/pingpong_buffer.sv
  - verilog/stereo_out_reg.sv
  - verilog/voice_fx_top.sv
  - target: test
    files:
      - verif/tb_voice_fx.sv

/* verif/voice_fx_vectors.txt */
# test <name> <mode: normal light deep>
# stim <left hex> <right hex> <l_vld> <r_vld>   expect <ldata hex> <rdata hex>
test pass_basic normal
stim 5a 00 1 0
expect 5a 00
stim 00 c3 0 1
expect 5a c3
stim 7e 81 1 1
expect 7e 81
stim ff 00 1 0
expect ff 81
stim 00 01 0 1
expect ff 01
test light_fill light
stim 11 21 1 1
stim 12 22 1 1
stim 13 23 1 1
stim 14 24 1 1
stim 15 25 1 1
stim 16 26 1 1
expect 11 21
expect 12 22
expect 13 23
expect 14 24
test deep_split deep
stim 31 41 1 1
stim 32 00 1 0
stim 00 42 0 1
stim 33 43 1 1
stim 34 44 1 1
stim 35 45 1 1
stim 36 00 1 0
expect 31 41
expect 32 42
expect 33 43
expect 34 44
test pass_mixed normal
stim 3c 00 1 0
expect 3c 00
stim 00 a5 0 1
stim 96 69 1 1
expect 96 69
stim 00 e1 0 1
expect 96 e1
